// ==== vlog.f ====
+incdir+include
source/htif_pkg.sv
source/htif_fifo.sv
source/htif_reg_port.sv
source/mem_axi_bridge.sv
source/htif_bridge_top.sv
sim/tb_htif_bridge.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_htif_bridge
FILELIST = vlog.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "Test OK" $(LOG); then \
		echo "simulation did not finish"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/tb_htif_bridge.sv ====
`timescale 1ns/1ns
`include "htif_params.svh"

module tb_htif_bridge;

  import htif_pkg::*;

  localparam int DRV = 5;
  localparam int LIMIT = 200;

  logic host_clk = 1'b0;
  logic reset;
  ctl_addr_t ctl_aw, ctl_ar;
  ctl_wdata_t ctl_w;
  ctl_resp_t ctl_b;
  ctl_rdata_t ctl_r;
  logic ctl_aw_valid, ctl_aw_ready, ctl_w_valid, ctl_w_ready;
  logic ctl_b_valid, ctl_b_ready, ctl_ar_valid, ctl_ar_ready;
  logic ctl_r_valid, ctl_r_ready, target_reset;
  logic host_in_valid, host_in_ready, host_out_valid, host_out_ready;
  host_word_t host_in_data, host_out_data, mem_wdata, axi_w_data;
  mem_cmd_t mem_cmd;
  mem_resp_t mem_resp;
  logic mem_cmd_valid, mem_cmd_ready, mem_wdata_valid, mem_wdata_ready;
  logic mem_resp_valid, mem_resp_ready;
  axi_req_t axi_ar, axi_aw;
  axi_rdata_t axi_r;
  logic axi_ar_valid, axi_ar_ready, axi_aw_valid, axi_aw_ready;
  logic axi_w_last, axi_w_valid, axi_w_ready;
  logic axi_r_valid, axi_r_ready, axi_b_valid;

  // reference model state
  host_word_t ref_in[$];
  host_word_t ref_out[$];
  mem_tag_t ref_tags[$];
  host_word_t exp_in_word, exp_rdata, exp_wdata, exp_resp_data;
  logic in_ref_empty;
  host_id_t exp_bid, exp_rid;
  axi_addr_t exp_ar_addr, exp_aw_addr;
  mem_id_t exp_ar_id;
  mem_tag_t exp_resp_tag;
  logic stall_expected, w_fired;
  int seed = 32'hfc2b79ad;
  int value_errors, timeout_errors;
  int writes_issued, reads_issued, b_seen, r_seen;
  int pulses_expected, pulses_seen, beats_expected, beats_seen;

  htif_bridge_top i_htif_bridge_top (.*);

  always #20 host_clk = ~host_clk;

  task automatic show_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    value_errors++;
    $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
  endtask

  task automatic timed_out(input string what);
    timeout_errors++;
    $display("timeout while waiting for %s", what);
  endtask

  // host write, aw and w together, then wait for b
  task automatic host_write(input reg_index_t idx, input host_word_t data,
                            input host_id_t id);
    int n;
    ctl_aw.addr = {25'd0, idx, 2'b00};
    ctl_aw.id = id;
    ctl_w = data;
    exp_bid = id;
    ctl_aw_valid = 1'b1;
    ctl_w_valid = 1'b1;
    writes_issued++;
    n = 0;
    do
    begin
      @(posedge host_clk);
      n++;
    end
    while (!ctl_aw_ready && n < LIMIT);
    if (!ctl_aw_ready)
      timed_out("ctl_aw_ready");
    #DRV;
    ctl_aw_valid = 1'b0;
    ctl_w_valid = 1'b0;
    n = 0;
    do
    begin
      @(posedge host_clk);
      n++;
    end
    while (!ctl_b_valid && n < LIMIT);
    if (!ctl_b_valid)
      timed_out("ctl_b_valid");
    #DRV;
  endtask

  // expected read data comes from the reference host_out queue
  task automatic host_read(input reg_index_t idx, input host_id_t id);
    int n;
    if (idx == `HTIF_REG_COUNT)
      exp_rdata = ref_out.size();
    else if (idx == `HTIF_REG_RDATA && ref_out.size() > 0)
      exp_rdata = ref_out[0];
    else
      exp_rdata = '0;
    exp_rid = id;
    ctl_ar.addr = {25'd0, idx, 2'b00};
    ctl_ar.id = id;
    ctl_ar_valid = 1'b1;
    reads_issued++;
    n = 0;
    do
    begin
      @(posedge host_clk);
      n++;
    end
    while (!ctl_ar_ready && n < LIMIT);
    if (!ctl_ar_ready)
      timed_out("ctl_ar_ready");
    #DRV;
    ctl_ar_valid = 1'b0;
    n = 0;
    do
    begin
      @(posedge host_clk);
      n++;
    end
    while (!ctl_r_valid && n < LIMIT);
    if (!ctl_r_valid)
      timed_out("ctl_r_valid");
    #DRV;
  endtask

  // target offers one word on host_out
  task automatic target_offer(input host_word_t data);
    int n;
    host_out_data = data;
    host_out_valid = 1'b1;
    n = 0;
    do
    begin
      @(posedge host_clk);
      n++;
    end
    while (!host_out_ready && n < LIMIT);
    if (!host_out_ready)
      timed_out("host_out_ready");
    #DRV;
    host_out_valid = 1'b0;
  endtask

  // target memory command, rw high for a write
  task automatic target_mem(input mem_word_addr_t addr, input mem_tag_t tag,
                            input logic rw, input host_word_t data);
    int n;
    mem_cmd.addr = addr;
    mem_cmd.tag = tag;
    mem_cmd.rw = rw;
    // window base in the top nibble, word address scaled to bytes
    exp_ar_addr = (axi_addr_t'(`HTIF_MEM_BASE) << 28) | (axi_addr_t'(addr) << 2);
    exp_aw_addr = exp_ar_addr;
    exp_ar_id = mem_id_t'(tag);
    exp_wdata = data;
    mem_wdata = data;
    mem_cmd_valid = 1'b1;
    mem_wdata_valid = rw;
    n = 0;
    do
    begin
      @(posedge host_clk);
      n++;
    end
    while (!mem_cmd_ready && n < LIMIT);
    if (!mem_cmd_ready)
      timed_out("mem_cmd_ready");
    #DRV;
    mem_cmd_valid = 1'b0;
    if (rw)
    begin
      beats_expected++;
      n = 0;
      do
      begin
        @(posedge host_clk);
        n++;
      end
      while (!mem_wdata_ready && n < LIMIT);
      if (!mem_wdata_ready)
        timed_out("mem_wdata_ready");
      #DRV;
      mem_wdata_valid = 1'b0;
    end
    else
      ref_tags.push_back(tag);
  endtask

  // memory answers the oldest outstanding read
  task automatic mem_answer(input host_word_t data);
    int n;
    exp_resp_tag = ref_tags.pop_front();
    exp_resp_data = data;
    axi_r.data = data;
    axi_r.id = {1'b0, exp_resp_tag};
    axi_r_valid = 1'b1;
    n = 0;
    do
    begin
      @(posedge host_clk);
      n++;
    end
    while (!(axi_r_ready && mem_resp_valid) && n < LIMIT);
    if (!(axi_r_ready && mem_resp_valid))
      timed_out("axi_r_ready with mem_resp_valid");
    #DRV;
    axi_r_valid = 1'b0;
  endtask

  // memory readiness is random, b follows each w beat
  always @(posedge host_clk)
  begin
    w_fired = axi_w_valid && axi_w_ready;
    #DRV;
    axi_b_valid = w_fired && !reset;
    axi_ar_ready = $random(seed) % 2;
    axi_aw_ready = $random(seed) % 2;
    axi_w_ready = $random(seed) % 2;
  end

  // reference queue upkeep and event counts
  always @(posedge host_clk)
  begin
    if (!reset)
    begin
      if (host_in_valid && host_in_ready && ref_in.size() > 0)
        void'(ref_in.pop_front());
      if (ctl_aw_valid && ctl_aw_ready && ctl_aw.addr[6:2] == `HTIF_REG_WDATA)
        ref_in.push_back(ctl_w);
      if (host_out_valid && host_out_ready)
        ref_out.push_back(host_out_data);
      if (ctl_r_valid && ctl_r_ready && ctl_ar.addr[6:2] == `HTIF_REG_RDATA
          && ref_out.size() > 0)
        void'(ref_out.pop_front());
      if (ctl_b_valid && ctl_b_ready)
        b_seen++;
      if (ctl_r_valid && ctl_r_ready)
        r_seen++;
      if (target_reset)
        pulses_seen++;
      if (axi_w_valid && axi_w_ready)
        beats_seen++;
    end
    exp_in_word <= (ref_in.size() > 0) ? ref_in[0] : '0;
    in_ref_empty <= (ref_in.size() == 0);
  end

  host_in_order: assert property (@(posedge host_clk) disable iff (reset)
    host_in_valid && host_in_ready |-> host_in_data == exp_in_word)
    else show_mismatch("host_in_data", host_in_data, exp_in_word);
  host_in_known: assert property (@(posedge host_clk) disable iff (reset)
    host_in_valid |-> !in_ref_empty)
    else show_mismatch("host_in_valid", host_in_valid, 0);
  rdata_value: assert property (@(posedge host_clk) disable iff (reset)
    ctl_r_valid && ctl_r_ready |-> ctl_r.data == exp_rdata)
    else show_mismatch("ctl_r.data", ctl_r.data, exp_rdata);
  rdata_id: assert property (@(posedge host_clk) disable iff (reset)
    ctl_r_valid |-> ctl_r.id == exp_rid && ctl_r.last)
    else show_mismatch("ctl_r.id", ctl_r.id, exp_rid);
  bresp_id: assert property (@(posedge host_clk) disable iff (reset)
    ctl_b_valid |-> ctl_b.id == exp_bid)
    else show_mismatch("ctl_b.id", ctl_b.id, exp_bid);
  write_stalls: assert property (@(posedge host_clk) disable iff (reset)
    stall_expected |-> !ctl_aw_ready)
    else show_mismatch("ctl_aw_ready", ctl_aw_ready, 0);
  // w is taken on the same cycle as aw
  w_with_aw: assert property (@(posedge host_clk) disable iff (reset)
    ctl_aw_valid && ctl_aw_ready |-> ctl_w_ready)
    else show_mismatch("ctl_w_ready", ctl_w_ready, 1);
  w_stalls: assert property (@(posedge host_clk) disable iff (reset)
    stall_expected |-> !ctl_w_ready)
    else show_mismatch("ctl_w_ready", ctl_w_ready, 0);
  reset_one_cycle: assert property (@(posedge host_clk) disable iff (reset)
    target_reset |=> !target_reset)
    else show_mismatch("target_reset", target_reset, 0);
  ar_addr: assert property (@(posedge host_clk) disable iff (reset)
    axi_ar_valid |-> axi_ar.addr == exp_ar_addr && axi_ar.id == exp_ar_id)
    else show_mismatch("axi_ar", axi_ar, {exp_ar_addr, exp_ar_id});
  aw_addr: assert property (@(posedge host_clk) disable iff (reset)
    axi_aw_valid |-> axi_aw.addr == exp_aw_addr && axi_aw.id == '0)
    else show_mismatch("axi_aw", axi_aw, {exp_aw_addr, 6'd0});
  w_beat: assert property (@(posedge host_clk) disable iff (reset)
    axi_w_valid |-> axi_w_data == exp_wdata && axi_w_last)
    else show_mismatch("axi_w_data", axi_w_data, exp_wdata);
  resp_value: assert property (@(posedge host_clk) disable iff (reset)
    mem_resp_valid |-> mem_resp.data == exp_resp_data && mem_resp.tag == exp_resp_tag)
    else show_mismatch("mem_resp", mem_resp, {exp_resp_data, exp_resp_tag});

  initial
  begin
    int n;
    host_id_t id;
    reset = 1'b1;
    {ctl_aw, ctl_ar, ctl_w, ctl_aw_valid, ctl_w_valid, ctl_ar_valid} = '0;
    ctl_b_ready = 1'b1;
    ctl_r_ready = 1'b1;
    host_in_ready = 1'b1;
    {host_out_valid, host_out_data, mem_cmd, mem_cmd_valid} = '0;
    {mem_wdata, mem_wdata_valid, axi_r, axi_r_valid, axi_b_valid} = '0;
    {axi_ar_ready, axi_aw_ready, axi_w_ready, stall_expected} = '0;
    mem_resp_ready = 1'b1;
    id = 12'h100;
    repeat (16) @(posedge host_clk);
    #DRV;
    reset = 1'b0;
    // host_in order
    for (int i = 0; i < 5; i++)
      host_write(`HTIF_REG_WDATA, $random(seed), id++);
    // host_out, count, empty and unmapped reads
    for (int i = 0; i < 6; i++)
      target_offer($random(seed));
    repeat (2) @(posedge host_clk);
    #DRV;
    host_read(`HTIF_REG_COUNT, id++);
    for (int i = 0; i < 6; i++)
      host_read(`HTIF_REG_RDATA, id++);
    host_read(`HTIF_REG_RDATA, id++);
    host_read(`HTIF_REG_COUNT, id++);
    host_read(5'd9, id++);
    // fill host_in, the 33rd write must stall
    host_in_ready = 1'b0;
    for (int i = 0; i < 32; i++)
      host_write(`HTIF_REG_WDATA, $random(seed), id++);
    fork
      host_write(`HTIF_REG_WDATA, $random(seed), id++);
      begin
        stall_expected = 1'b1;
        repeat (8) @(posedge host_clk);
        #DRV;
        stall_expected = 1'b0;
        host_in_ready = 1'b1;
        @(posedge host_clk);
        #DRV;
        host_in_ready = 1'b0;
      end
    join
    // target reset while the queue is full
    pulses_expected++;
    host_write(`HTIF_REG_RESET, 32'h0, id++);
    host_in_ready = 1'b1;
    n = 0;
    while (ref_in.size() > 0 && n < LIMIT)
    begin
      @(posedge host_clk);
      n++;
    end
    if (ref_in.size() > 0)
      timed_out("host_in drain");
    #DRV;
    // memory reads, answered in order
    for (int i = 0; i < 3; i++)
      target_mem($random(seed), 5'd3 + i, 1'b0, '0);
    for (int i = 0; i < 3; i++)
      mem_answer($random(seed));
    // memory writes
    for (int i = 0; i < 3; i++)
      target_mem($random(seed), 5'd0, 1'b1, $random(seed));
    repeat (4) @(posedge host_clk);
    // every transaction answered exactly once
    assert (b_seen == writes_issued)
      else show_mismatch("ctl_b count", b_seen, writes_issued);
    assert (r_seen == reads_issued)
      else show_mismatch("ctl_r count", r_seen, reads_issued);
    assert (pulses_seen == pulses_expected)
      else show_mismatch("target_reset pulses", pulses_seen, pulses_expected);
    assert (beats_seen == beats_expected)
      else show_mismatch("axi_w beats", beats_seen, beats_expected);
    assert (ref_out.size() == 0)
      else show_mismatch("host_out left", ref_out.size(), 0);
    $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// ==== source/htif_bridge_top.sv ====
`timescale 1ns/1ns
`include "htif_params.svh"

module htif_bridge_top (
  input  logic                 host_clk,
  input  logic                 reset,
  // host control port
  input  htif_pkg::ctl_addr_t  ctl_aw,
  input  logic                 ctl_aw_valid,
  output logic                 ctl_aw_ready,
  input  htif_pkg::ctl_wdata_t ctl_w,
  input  logic                 ctl_w_valid,
  output logic                 ctl_w_ready,
  output htif_pkg::ctl_resp_t  ctl_b,
  output logic                 ctl_b_valid,
  input  logic                 ctl_b_ready,
  input  htif_pkg::ctl_addr_t  ctl_ar,
  input  logic                 ctl_ar_valid,
  output logic                 ctl_ar_ready,
  output htif_pkg::ctl_rdata_t ctl_r,
  output logic                 ctl_r_valid,
  input  logic                 ctl_r_ready,
  output logic                 target_reset,
  // target side queues
  output logic                 host_in_valid,
  output htif_pkg::host_word_t host_in_data,
  input  logic                 host_in_ready,
  input  logic                 host_out_valid,
  input  htif_pkg::host_word_t host_out_data,
  output logic                 host_out_ready,
  // target memory requests
  input  htif_pkg::mem_cmd_t   mem_cmd,
  input  logic                 mem_cmd_valid,
  output logic                 mem_cmd_ready,
  input  htif_pkg::host_word_t mem_wdata,
  input  logic                 mem_wdata_valid,
  output logic                 mem_wdata_ready,
  output htif_pkg::mem_resp_t  mem_resp,
  output logic                 mem_resp_valid,
  input  logic                 mem_resp_ready,
  // memory master
  output htif_pkg::axi_req_t   axi_ar,
  output logic                 axi_ar_valid,
  input  logic                 axi_ar_ready,
  output htif_pkg::axi_req_t   axi_aw,
  output logic                 axi_aw_valid,
  input  logic                 axi_aw_ready,
  output htif_pkg::host_word_t axi_w_data,
  output logic                 axi_w_last,
  output logic                 axi_w_valid,
  input  logic                 axi_w_ready,
  input  htif_pkg::axi_rdata_t axi_r,
  input  logic                 axi_r_valid,
  output logic                 axi_r_ready,
  input  logic                 axi_b_valid
);

  import htif_pkg::*;

  // host_in queue, host to target
  logic        in_push;
  host_word_t  in_data;
  logic        in_full;
  logic        in_empty;
  logic        in_pop;
  // host_out queue, target to host
  logic        out_pop;
  host_word_t  out_data;
  logic        out_empty;
  logic        out_full;
  fifo_count_t out_count;

  // head of host_in goes out as soon as it is there
  assign host_in_valid = !in_empty;
  assign in_pop        = host_in_valid && host_in_ready;
  assign host_out_ready = !out_full;

  htif_reg_port i_reg_port (
    .host_clk     (host_clk),
    .reset        (reset),
    .ctl_aw       (ctl_aw),
    .ctl_aw_valid (ctl_aw_valid),
    .ctl_aw_ready (ctl_aw_ready),
    .ctl_w        (ctl_w),
    .ctl_w_valid  (ctl_w_valid),
    .ctl_w_ready  (ctl_w_ready),
    .ctl_b        (ctl_b),
    .ctl_b_valid  (ctl_b_valid),
    .ctl_b_ready  (ctl_b_ready),
    .ctl_ar       (ctl_ar),
    .ctl_ar_valid (ctl_ar_valid),
    .ctl_ar_ready (ctl_ar_ready),
    .ctl_r        (ctl_r),
    .ctl_r_valid  (ctl_r_valid),
    .ctl_r_ready  (ctl_r_ready),
    .in_push      (in_push),
    .in_data      (in_data),
    .in_full      (in_full),
    .out_pop      (out_pop),
    .out_data     (out_data),
    .out_empty    (out_empty),
    .out_count    (out_count),
    .target_reset (target_reset)
  );

  htif_fifo #(
    .WIDTH (`HTIF_DATA_W),
    .DEPTH (`HTIF_FIFO_DEPTH)
  ) host_in_fifo (
    .clk   (host_clk),
    .reset (reset),
    .push  (in_push),
    .pop   (in_pop),
    .din   (in_data),
    .dout  (host_in_data),
    .empty (in_empty),
    .full  (in_full),
    .count ()
  );

  // target offers only when ready, full pushes are dropped by the queue
  htif_fifo #(
    .WIDTH (`HTIF_DATA_W),
    .DEPTH (`HTIF_FIFO_DEPTH)
  ) host_out_fifo (
    .clk   (host_clk),
    .reset (reset),
    .push  (host_out_valid),
    .pop   (out_pop),
    .din   (host_out_data),
    .dout  (out_data),
    .empty (out_empty),
    .full  (out_full),
    .count (out_count)
  );

  mem_axi_bridge i_mem_axi_bridge (
    .host_clk        (host_clk),
    .reset           (reset),
    .mem_cmd         (mem_cmd),
    .mem_cmd_valid   (mem_cmd_valid),
    .mem_cmd_ready   (mem_cmd_ready),
    .mem_wdata       (mem_wdata),
    .mem_wdata_valid (mem_wdata_valid),
    .mem_wdata_ready (mem_wdata_ready),
    .mem_resp        (mem_resp),
    .mem_resp_valid  (mem_resp_valid),
    .mem_resp_ready  (mem_resp_ready),
    .axi_ar          (axi_ar),
    .axi_ar_valid    (axi_ar_valid),
    .axi_ar_ready    (axi_ar_ready),
    .axi_aw          (axi_aw),
    .axi_aw_valid    (axi_aw_valid),
    .axi_aw_ready    (axi_aw_ready),
    .axi_w_data      (axi_w_data),
    .axi_w_last      (axi_w_last),
    .axi_w_valid     (axi_w_valid),
    .axi_w_ready     (axi_w_ready),
    .axi_r           (axi_r),
    .axi_r_valid     (axi_r_valid),
    .axi_r_ready     (axi_r_ready),
    .axi_b_valid     (axi_b_valid)
  );

endmodule

// ==== source/mem_axi_bridge.sv ====
`timescale 1ns/1ns
`include "htif_params.svh"

module mem_axi_bridge (
  input  logic                 host_clk,
  input  logic                 reset,
  // target requests
  input  htif_pkg::mem_cmd_t   mem_cmd,
  input  logic                 mem_cmd_valid,
  output logic                 mem_cmd_ready,
  input  htif_pkg::host_word_t mem_wdata,
  input  logic                 mem_wdata_valid,
  output logic                 mem_wdata_ready,
  output htif_pkg::mem_resp_t  mem_resp,
  output logic                 mem_resp_valid,
  input  logic                 mem_resp_ready,
  // memory master
  output htif_pkg::axi_req_t   axi_ar,
  output logic                 axi_ar_valid,
  input  logic                 axi_ar_ready,
  output htif_pkg::axi_req_t   axi_aw,
  output logic                 axi_aw_valid,
  input  logic                 axi_aw_ready,
  output htif_pkg::host_word_t axi_w_data,
  output logic                 axi_w_last,
  output logic                 axi_w_valid,
  input  logic                 axi_w_ready,
  input  htif_pkg::axi_rdata_t axi_r,
  input  logic                 axi_r_valid,
  output logic                 axi_r_ready,
  input  logic                 axi_b_valid
);

  import htif_pkg::*;

  mem_state_e state;
  axi_addr_t  byte_addr;
  // write responses still owed by memory
  logic [3:0] b_pending;
  logic       w_fire;

  always_ff @(posedge host_clk)
  begin
    if (reset)
      state <= mem_idle;
    else
    begin
      case (state)
        mem_idle:
        begin
          if (mem_cmd_valid)
            state <= mem_cmd.rw ? mem_write_addr : mem_read;
        end
        mem_read:
        begin
          if (axi_ar_ready)
            state <= mem_idle;
        end
        mem_write_addr:
        begin
          if (axi_aw_ready)
            state <= mem_write_data;
        end
        mem_write_data:
        begin
          if (w_fire)
            state <= mem_idle;
        end
        default:
          state <= mem_idle;
      endcase
    end
  end

  // word address into the window, byte aligned
  assign byte_addr = {`HTIF_MEM_BASE, mem_cmd.addr, 2'b00};

  assign axi_ar_valid = (state == mem_read);
  assign axi_ar.addr  = byte_addr;
  // tag rides in the id, comes back on r
  assign axi_ar.id    = {1'b0, mem_cmd.tag};

  assign axi_aw_valid = (state == mem_write_addr);
  assign axi_aw.addr  = byte_addr;
  assign axi_aw.id    = '0;

  // command is done once its address is taken
  assign mem_cmd_ready = (axi_ar_valid && axi_ar_ready) || (axi_aw_valid && axi_aw_ready);

  // one beat per write
  assign axi_w_valid     = (state == mem_write_data) && mem_wdata_valid;
  assign axi_w_data      = mem_wdata;
  assign axi_w_last      = axi_w_valid;
  assign mem_wdata_ready = (state == mem_write_data) && axi_w_ready;
  assign w_fire          = axi_w_valid && axi_w_ready;

  // read data straight back to the target
  assign mem_resp_valid = axi_r_valid;
  assign mem_resp.data  = axi_r.data;
  assign mem_resp.tag   = axi_r.id[`HTIF_MEM_TAG_W-1:0];
  assign axi_r_ready    = mem_resp_ready;

  // b is always accepted, only tracked for checking
  always_ff @(posedge host_clk)
  begin
    if (reset)
      b_pending <= '0;
    else if (w_fire && !axi_b_valid)
      b_pending <= b_pending + 1'b1;
    else if (axi_b_valid && !w_fire)
      b_pending <= b_pending - 1'b1;
  end

  aw_valid_holds: assert property (
    @(posedge host_clk) disable iff (reset)
    axi_aw_valid && !axi_aw_ready |=> axi_aw_valid
  );

  b_only_after_write: assert property (
    @(posedge host_clk) disable iff (reset)
    axi_b_valid |-> (b_pending != '0)
  );

endmodule

// ==== source/htif_reg_port.sv ====
`timescale 1ns/1ns
`include "htif_params.svh"

module htif_reg_port (
  input  logic                  host_clk,
  input  logic                  reset,
  // host write address and data
  input  htif_pkg::ctl_addr_t   ctl_aw,
  input  logic                  ctl_aw_valid,
  output logic                  ctl_aw_ready,
  input  htif_pkg::ctl_wdata_t  ctl_w,
  input  logic                  ctl_w_valid,
  output logic                  ctl_w_ready,
  // host write response
  output htif_pkg::ctl_resp_t   ctl_b,
  output logic                  ctl_b_valid,
  input  logic                  ctl_b_ready,
  // host read address and data
  input  htif_pkg::ctl_addr_t   ctl_ar,
  input  logic                  ctl_ar_valid,
  output logic                  ctl_ar_ready,
  output htif_pkg::ctl_rdata_t  ctl_r,
  output logic                  ctl_r_valid,
  input  logic                  ctl_r_ready,
  // host_in queue
  output logic                  in_push,
  output htif_pkg::host_word_t  in_data,
  input  logic                  in_full,
  // host_out queue
  output logic                  out_pop,
  input  htif_pkg::host_word_t  out_data,
  input  logic                  out_empty,
  input  htif_pkg::fifo_count_t out_count,
  output logic                  target_reset
);

  import htif_pkg::*;

  wr_state_e  wr_state;
  rd_state_e  rd_state;
  reg_index_t wr_index;
  reg_index_t rd_index;
  host_id_t   wr_id;
  host_id_t   rd_id;
  logic       wr_to_data;
  logic       wr_to_reset;
  logic       wr_go;
  host_word_t rd_word;

  // write side FSM
  always_ff @(posedge host_clk)
  begin
    if (reset)
      wr_state <= wr_idle;
    else
    begin
      case (wr_state)
        wr_idle:
        begin
          // aw and w arrive together
          if (ctl_aw_valid && ctl_w_valid)
            wr_state <= wr_push;
        end
        wr_push:
        begin
          // stalls here while host_in is full
          if (wr_go)
            wr_state <= wr_ack;
        end
        wr_ack:
        begin
          if (ctl_b_ready)
            wr_state <= wr_idle;
        end
        default:
          wr_state <= wr_idle;
      endcase
    end
  end

  // read side FSM
  always_ff @(posedge host_clk)
  begin
    if (reset)
      rd_state <= rd_idle;
    else
    begin
      case (rd_state)
        rd_idle:
        begin
          if (ctl_ar_valid)
            rd_state <= rd_data;
        end
        rd_data:
        begin
          if (ctl_r_ready)
            rd_state <= rd_idle;
        end
        default:
          rd_state <= rd_idle;
      endcase
    end
  end

  // index and id captured at the start of each transaction
  always_ff @(posedge host_clk)
  begin
    if ((wr_state == wr_idle) && ctl_aw_valid && ctl_w_valid)
    begin
      wr_index <= ctl_aw.addr[`HTIF_REG_ADDR_W+1:2];
      wr_id    <= ctl_aw.id;
    end
    if ((rd_state == rd_idle) && ctl_ar_valid)
    begin
      rd_index <= ctl_ar.addr[`HTIF_REG_ADDR_W+1:2];
      rd_id    <= ctl_ar.id;
    end
  end

  // write decode
  assign wr_to_data  = (wr_index == `HTIF_REG_WDATA);
  assign wr_to_reset = (wr_index == `HTIF_REG_RESET);
  // data writes wait for room, everything else goes at once
  assign wr_go = (wr_state == wr_push) && (!wr_to_data || !in_full);

  assign ctl_aw_ready = wr_go;
  assign ctl_w_ready  = wr_go;
  // w data is still held by the host during wr_push
  assign in_push      = wr_go && wr_to_data;
  assign in_data      = ctl_w;
  // single cycle pulse toward the target
  assign target_reset = wr_go && wr_to_reset;

  assign ctl_b_valid = (wr_state == wr_ack);
  assign ctl_b.id    = wr_id;

  // read mux, unmapped and empty reads give zero
  always_comb
  begin
    case (rd_index)
      `HTIF_REG_COUNT: rd_word = host_word_t'(out_count);
      `HTIF_REG_RDATA: rd_word = out_empty ? '0 : out_data;
      default:         rd_word = '0;
    endcase
  end

  assign ctl_ar_ready = (rd_state == rd_idle);
  assign ctl_r_valid  = (rd_state == rd_data);
  assign ctl_r.data   = rd_word;
  assign ctl_r.id     = rd_id;
  // single beat reads
  assign ctl_r.last   = 1'b1;

  // pop on the r handshake of a data read
  assign out_pop = ctl_r_valid && ctl_r_ready && (rd_index == `HTIF_REG_RDATA) && !out_empty;

  in_push_has_room: assert property (
    @(posedge host_clk) disable iff (reset)
    in_push |-> !in_full
  );

  b_valid_holds: assert property (
    @(posedge host_clk) disable iff (reset)
    ctl_b_valid && !ctl_b_ready |=> ctl_b_valid
  );

endmodule

// ==== source/htif_fifo.sv ====
`timescale 1ns/1ns
`include "htif_params.svh"

module htif_fifo #(
  parameter int WIDTH = `HTIF_DATA_W,
  parameter int DEPTH = `HTIF_FIFO_DEPTH
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  push,
  input  logic                  pop,
  input  logic [WIDTH-1:0]      din,
  output logic [WIDTH-1:0]      dout,
  output logic                  empty,
  output logic                  full,
  output htif_pkg::fifo_count_t count
);

  localparam int PTR_W = $clog2(DEPTH);

  // storage, no reset needed
  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr_next;
  logic [PTR_W-1:0] rd_ptr_next;
  logic             do_push;
  logic             do_pop;

  // push into a full queue only when a pop frees a slot
  assign do_push = push && (pop || !full);
  assign do_pop  = pop && !empty;

  assign wr_ptr_next = do_push ? wr_ptr + 1'b1 : wr_ptr;
  assign rd_ptr_next = do_pop ? rd_ptr + 1'b1 : rd_ptr;

  // first word falls through
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      empty  <= 1'b1;
      full   <= 1'b0;
      count  <= '0;
    end
    else
    begin
      wr_ptr <= wr_ptr_next;
      rd_ptr <= rd_ptr_next;
      // pointers meet after a pop, so the last word left
      if (do_pop && (rd_ptr_next == wr_ptr_next) && !full)
        empty <= 1'b1;
      else if (do_push && !do_pop)
        empty <= 1'b0;
      // pointers meet after a push, queue wrapped
      if (do_push && (rd_ptr_next == wr_ptr_next))
        full <= 1'b1;
      else if (do_pop && !do_push)
        full <= 1'b0;
      // count moves only when exactly one side fires
      if (do_push ^ do_pop)
        count <= do_push ? count + 1'b1 : count - 1'b1;
    end
  end

  count_in_range: assert property (
    @(posedge clk) disable iff (reset)
    count <= DEPTH
  );

endmodule

// ==== source/htif_pkg.sv ====
`include "htif_params.svh"

package htif_pkg;

  // plain vectors
  typedef logic [`HTIF_DATA_W-1:0]                 host_word_t;
  typedef logic [`HTIF_REG_ADDR_W-1:0]             reg_index_t;
  typedef logic [`HTIF_HOST_ID_W-1:0]              host_id_t;
  typedef logic [`HTIF_MEM_ID_W-1:0]               mem_id_t;
  typedef logic [`HTIF_MEM_TAG_W-1:0]              mem_tag_t;
  typedef logic [`HTIF_MEM_ADDR_W-1:0]             mem_word_addr_t;
  typedef logic [31:0]                             axi_addr_t;
  // one bit above the pointer so a full queue is representable
  typedef logic [$clog2(`HTIF_FIFO_DEPTH):0]       fifo_count_t;

  // host control port channels
  typedef struct packed {
    axi_addr_t addr;
    host_id_t  id;
  } ctl_addr_t;

  typedef host_word_t ctl_wdata_t;

  typedef struct packed {
    host_id_t id;
  } ctl_resp_t;

  typedef struct packed {
    host_word_t data;
    host_id_t   id;
    logic       last;
  } ctl_rdata_t;

  // target memory requests, rw high for a write
  typedef struct packed {
    mem_word_addr_t addr;
    mem_tag_t       tag;
    logic           rw;
  } mem_cmd_t;

  typedef struct packed {
    host_word_t data;
    mem_tag_t   tag;
  } mem_resp_t;

  // memory master channels
  typedef struct packed {
    axi_addr_t addr;
    mem_id_t   id;
  } axi_req_t;

  typedef struct packed {
    host_word_t data;
    mem_id_t    id;
  } axi_rdata_t;

  typedef enum logic {rd_idle, rd_data} rd_state_e;
  typedef enum logic [1:0] {wr_idle, wr_push, wr_ack} wr_state_e;
  typedef enum logic [1:0] {mem_idle, mem_read, mem_write_addr, mem_write_data} mem_state_e;

endpackage

// ==== include/htif_params.svh ====
`ifndef HTIF_PARAMS_SVH
`define HTIF_PARAMS_SVH

// host word, also the memory data width
`define HTIF_DATA_W      32
// entries per queue
`define HTIF_FIFO_DEPTH  32
// word index into the register bank
`define HTIF_REG_ADDR_W  5
// id widths on the host and memory sides
`define HTIF_HOST_ID_W   12
`define HTIF_MEM_ID_W    6
// target request tag and word address
`define HTIF_MEM_TAG_W   5
`define HTIF_MEM_ADDR_W  26
// top nibble of the memory window
`define HTIF_MEM_BASE    4'h1

// register indices, read side
`define HTIF_REG_COUNT   5'd0
`define HTIF_REG_RDATA   5'd1
// register indices, write side
`define HTIF_REG_WDATA   5'd0
`define HTIF_REG_RESET   5'd31

`endif
